//--- conv_pkg.sv
// shared types for the frequency-domain convolution core
// import with conv_pkg::* in the module header
// a cacheline carries eight complex values, real part in the low half
package conv_pkg;

  localparam int ADDR_W = 58;
  localparam int MDATA_W = 14;
  localparam int PART_W = 32;
  localparam int CL_BITS = 512;
  localparam int CL_LANES = 8;
  // tag bit 0 is the kind, the rest is the map index
  localparam int MAP_W = MDATA_W - 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [MDATA_W-1:0] mdata_t;
  typedef logic [MAP_W-1:0] map_idx_t;
  typedef logic [15:0] count_t;
  typedef logic signed [PART_W-1:0] part_t;

  typedef struct packed {
    part_t im;
    part_t re;
  } complex_t;

  // raw view for the bus and fifo, lanes view for the datapath
  typedef union packed {
    logic [CL_BITS-1:0] raw;
    complex_t [CL_LANES-1:0] lanes;
  } cacheline_u;

  typedef struct packed {
    addr_t image_base;
    addr_t kernel_base;
    addr_t dest_base;
    count_t num_maps;
    count_t num_outputs;
  } job_cfg_t;

  typedef struct packed {
    complex_t image;
    complex_t kernel;
    logic first;
    logic last;
    logic valid;
  } lane_beat_t;

endpackage

//--- read_sequencer.sv
// read request sequencer
// latches the job on start, reads the D kernel lines, then the image
// lines in address order; an output may only start when a fifo slot
// is free, slots come back through slot_free
`timescale 1ns/1ps

module read_sequencer import conv_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  job_cfg_t cfg,
  output job_cfg_t job,
  output logic job_start,
  output logic rd_req_en,
  output addr_t rd_req_addr,
  output mdata_t rd_req_mdata,
  input  logic rd_req_almostfull,
  input  logic slot_free
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_KERNEL,
    S_IMAGE,
    S_FINISHED
  } state_t;

  state_t state;
  count_t map_idx;
  count_t out_idx;
  addr_t img_addr;
  logic [CW-1:0] credits;
  logic issue;
  logic take_slot;
  logic last_map;

  assign last_map = (map_idx == job.num_maps - 16'd1);

  // request decision, the request itself shows up next cycle
  always_comb begin
    issue = 1'b0;
    take_slot = 1'b0;
    case (state)
      S_KERNEL: issue = !rd_req_almostfull;
      S_IMAGE: begin
        if (!rd_req_almostfull) begin
          if (map_idx != '0) begin
            issue = 1'b1;
          end else if (credits != CW'(FIFO_DEPTH)) begin
            // first map of a new output reserves a fifo slot
            issue = 1'b1;
            take_slot = 1'b1;
          end
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      rd_req_en <= 1'b0;
      job_start <= 1'b0;
      credits <= '0;
      map_idx <= '0;
      out_idx <= '0;
    end else begin
      rd_req_en <= issue;
      job_start <= 1'b0;
      credits <= credits + CW'(take_slot) - CW'(slot_free);
      case (state)
        S_IDLE: begin
          if (start) begin
            job_start <= 1'b1;
            map_idx <= '0;
            out_idx <= '0;
            state <= S_KERNEL;
          end
        end
        S_KERNEL: begin
          if (issue) begin
            if (last_map) begin
              map_idx <= '0;
              state <= S_IMAGE;
            end else begin
              map_idx <= map_idx + 16'd1;
            end
          end
        end
        S_IMAGE: begin
          if (issue) begin
            if (last_map) begin
              map_idx <= '0;
              if (out_idx == job.num_outputs - 16'd1) begin
                state <= S_FINISHED;
              end else begin
                out_idx <= out_idx + 16'd1;
              end
            end else begin
              map_idx <= map_idx + 16'd1;
            end
          end
        end
        // wait until every reserved slot has been written out
        S_FINISHED: begin
          if (credits == '0) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // job and request payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      job <= cfg;
      img_addr <= cfg.image_base;
    end else if (state == S_IMAGE && issue) begin
      img_addr <= img_addr + addr_t'(1);
    end
    if (issue) begin
      if (state == S_KERNEL) begin
        rd_req_addr <= job.kernel_base + addr_t'(map_idx);
        rd_req_mdata <= {map_idx[MAP_W-1:0], 1'b1};
      end else begin
        rd_req_addr <= img_addr;
        rd_req_mdata <= {map_idx[MAP_W-1:0], 1'b0};
      end
    end
  end

  // slot accounting against the collector fifo
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= CW'(FIFO_DEPTH))
    else $error("reserved slot count above fifo depth");

endmodule

//--- response_router.sv
// read response router
// kernel responses fill the kernel store at the tag's map index;
// each image response is paired with the kernel line of its map
// and sent to all lanes one cycle later as a beat
`timescale 1ns/1ps

module response_router import conv_pkg::*; #(
  parameter int LANES = CL_LANES,
  parameter int KMAP_MAX = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic rd_rsp_valid,
  input  mdata_t rd_rsp_mdata,
  input  cacheline_u rd_rsp_data,
  input  count_t num_maps,
  output lane_beat_t [LANES-1:0] beats
);

  localparam int KW = $clog2(KMAP_MAX);

  cacheline_u kstore [KMAP_MAX];
  map_idx_t idx;
  logic is_kernel;
  logic img_hit;
  cacheline_u img_q;
  cacheline_u ker_q;
  logic first_q;
  logic last_q;
  logic valid_q;

  assign idx = rd_rsp_mdata[MDATA_W-1:1];
  assign is_kernel = rd_rsp_mdata[0];
  assign img_hit = rd_rsp_valid && !is_kernel;

  always_ff @(posedge clk) begin
    if (rd_rsp_valid && is_kernel) begin
      kstore[idx[KW-1:0]] <= rd_rsp_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= img_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (img_hit) begin
      img_q <= rd_rsp_data;
      ker_q <= kstore[idx[KW-1:0]];
      first_q <= (idx == '0);
      last_q <= ({3'b000, idx} == num_maps - 16'd1);
    end
  end

  // same flags for every lane, data split per lane
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      beats[k] = '{image: img_q.lanes[k], kernel: ker_q.lanes[k],
                   first: first_q, last: last_q, valid: valid_q};
    end
  end

  // tag must stay inside the latched job
  a_map_range: assert property (@(posedge clk) disable iff (reset)
    rd_rsp_valid |-> ({3'b000, idx} < num_maps))
    else $error("response map index outside the job");

endmodule

//--- mac_lane.sv
// one complex multiply-accumulate lane
// product registered one cycle after the beat, accumulator one later;
// loads on first, adds otherwise, result valid after the last beat
`timescale 1ns/1ps

module mac_lane import conv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  lane_beat_t beat,
  output complex_t result,
  output logic result_valid
);

  complex_t prod;
  logic p_valid;
  logic p_first;
  logic p_last;
  logic open_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      p_valid <= 1'b0;
      result_valid <= 1'b0;
      open_q <= 1'b0;
    end else begin
      p_valid <= beat.valid;
      result_valid <= p_valid && p_last;
      if (beat.valid) begin
        open_q <= !beat.last;
      end
    end
  end

  // low 32 bits only, wraps
  always_ff @(posedge clk) begin
    if (beat.valid) begin
      prod.re <= beat.image.re * beat.kernel.re - beat.image.im * beat.kernel.im;
      prod.im <= beat.image.re * beat.kernel.im + beat.image.im * beat.kernel.re;
      p_first <= beat.first;
      p_last <= beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (p_valid) begin
      if (p_first) begin
        result <= prod;
      end else begin
        result.re <= result.re + prod.re;
        result.im <= result.im + prod.im;
      end
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    (beat.valid && beat.first) |-> !open_q)
    else $error("new accumulation while the previous one is open");

endmodule

//--- write_collector.sv
// write collector
// packs the lane results into a cacheline, buffers it in a small fifo
// and writes the lines out from dest_base upward; done follows the
// last write response and clears on the next job start
`timescale 1ns/1ps

module write_collector import conv_pkg::*; #(
  parameter int LANES = CL_LANES,
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic job_start,
  input  addr_t dest_base,
  input  count_t num_outputs,
  input  complex_t [LANES-1:0] results,
  input  logic [LANES-1:0] result_valid,
  output logic wr_req_en,
  output addr_t wr_req_addr,
  output cacheline_u wr_req_data,
  input  logic wr_req_almostfull,
  input  logic wr_rsp_valid,
  output logic slot_free,
  output logic done
);

  localparam int PW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  cacheline_u mem [FIFO_DEPTH];
  cacheline_u line_in;
  logic [PW-1:0] wptr;
  logic [PW-1:0] rptr;
  logic [CW-1:0] count;
  logic push;
  logic pop;
  logic full;
  addr_t wr_addr;
  count_t rsp_cnt;

  always_comb begin
    line_in = '0;
    for (int k = 0; k < LANES; k++) begin
      line_in.lanes[k] = results[k];
    end
  end

  // lanes run in lockstep and report together
  assign push = &result_valid;
  assign full = (count == CW'(FIFO_DEPTH));
  assign pop = (count != '0) && !wr_req_almostfull;
  assign slot_free = wr_req_en;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= line_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wptr <= '0;
      rptr <= '0;
      count <= '0;
      wr_req_en <= 1'b0;
      rsp_cnt <= '0;
      done <= 1'b0;
    end else begin
      if (push) begin
        wptr <= (wptr == PW'(FIFO_DEPTH - 1)) ? '0 : wptr + PW'(1);
      end
      if (pop) begin
        rptr <= (rptr == PW'(FIFO_DEPTH - 1)) ? '0 : rptr + PW'(1);
      end
      count <= count + CW'(push) - CW'(pop);
      wr_req_en <= pop;
      if (job_start) begin
        rsp_cnt <= '0;
        done <= 1'b0;
      end else if (wr_rsp_valid) begin
        rsp_cnt <= rsp_cnt + 16'd1;
        if (rsp_cnt + 16'd1 == num_outputs) begin
          done <= 1'b1;
        end
      end
    end
  end

  // outgoing line and address
  always_ff @(posedge clk) begin
    if (job_start) begin
      wr_addr <= dest_base;
    end else if (pop) begin
      wr_addr <= wr_addr + addr_t'(1);
    end
    if (pop) begin
      wr_req_data <= mem[rptr];
      wr_req_addr <= wr_addr;
    end
  end

  // sequencer credits must keep the fifo from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("output fifo written while full");

endmodule

//--- conv_top.sv
// top level of the convolution core
// fetches the kernel lines, streams image lines through the mac lanes
// and writes one output line per D input maps
// lane count, fifo depth and max map count are set here
`timescale 1ns/1ps

module conv_top import conv_pkg::*; #(
  parameter int LANES = CL_LANES,
  parameter int FIFO_DEPTH = 8,
  parameter int KMAP_MAX = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  job_cfg_t cfg,
  output logic rd_req_en,
  output addr_t rd_req_addr,
  output mdata_t rd_req_mdata,
  input  logic rd_req_almostfull,
  input  logic rd_rsp_valid,
  input  mdata_t rd_rsp_mdata,
  input  cacheline_u rd_rsp_data,
  output logic wr_req_en,
  output addr_t wr_req_addr,
  output cacheline_u wr_req_data,
  input  logic wr_req_almostfull,
  input  logic wr_rsp_valid,
  output logic done
);

  job_cfg_t job;
  logic job_start;
  logic slot_free;
  lane_beat_t [LANES-1:0] beats;
  complex_t [LANES-1:0] results;
  logic [LANES-1:0] result_valid;

  read_sequencer #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_seq (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg              (cfg),
    .job              (job),
    .job_start        (job_start),
    .rd_req_en        (rd_req_en),
    .rd_req_addr      (rd_req_addr),
    .rd_req_mdata     (rd_req_mdata),
    .rd_req_almostfull(rd_req_almostfull),
    .slot_free        (slot_free)
  );

  response_router #(
    .LANES   (LANES),
    .KMAP_MAX(KMAP_MAX)
  ) u_router (
    .clk         (clk),
    .reset       (reset),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_mdata(rd_rsp_mdata),
    .rd_rsp_data (rd_rsp_data),
    .num_maps    (job.num_maps),
    .beats       (beats)
  );

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    mac_lane u_lane (
      .clk         (clk),
      .reset       (reset),
      .beat        (beats[k]),
      .result      (results[k]),
      .result_valid(result_valid[k])
    );
  end

  write_collector #(
    .LANES     (LANES),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_collector (
    .clk              (clk),
    .reset            (reset),
    .job_start        (job_start),
    .dest_base        (job.dest_base),
    .num_outputs      (job.num_outputs),
    .results          (results),
    .result_valid     (result_valid),
    .wr_req_en        (wr_req_en),
    .wr_req_addr      (wr_req_addr),
    .wr_req_data      (wr_req_data),
    .wr_req_almostfull(wr_req_almostfull),
    .wr_rsp_valid     (wr_rsp_valid),
    .slot_free        (slot_free),
    .done             (done)
  );

endmodule

//--- tb_clock.sv
// testbench clock and reset source
// 10 ns clock, reset held high for the first 5 rising edges
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // released 1 ns after the fifth edge, like all other stimulus
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- tb_memory.sv
// host memory model for the convolution core testbench
// sparse line store, answers reads in request order after 1 to 6 cycles,
// stores writes and acknowledges them after a random delay
// with bp_enable set both almostfull signals toggle at random;
// a request seen one cycle after almostfull sets a bit in proto_err
`timescale 1ns/1ps

module tb_memory import conv_pkg::*; #(
  parameter int SEED = 52723
) (
  input  logic clk,
  input  logic bp_enable,
  input  logic rd_req_en,
  input  addr_t rd_req_addr,
  input  mdata_t rd_req_mdata,
  output logic rd_req_almostfull,
  output logic rd_rsp_valid,
  output mdata_t rd_rsp_mdata,
  output cacheline_u rd_rsp_data,
  input  logic wr_req_en,
  input  addr_t wr_req_addr,
  input  cacheline_u wr_req_data,
  output logic wr_req_almostfull,
  output logic wr_rsp_valid,
  output logic [1:0] proto_err
);

  cacheline_u store [addr_t];
  cacheline_u rq_data [$];
  mdata_t rq_tag [$];
  int rq_due [$];
  int wq_due [$];
  addr_t log_addr_q [$];
  mdata_t log_tag_q [$];
  logic rd_af_seen;
  logic wr_af_seen;
  int cycle;
  integer seed;

  function automatic void load_line(input addr_t a, input cacheline_u d);
    store[a] = d;
  endfunction

  // unwritten lines read back as a pattern built from the full address
  function automatic cacheline_u peek_line(input addr_t a);
    cacheline_u d;
    if (store.exists(a)) begin
      d = store[a];
    end else begin
      d.raw = {8{{6'h2a, a}}};
    end
    return d;
  endfunction

  function automatic void clear_log();
    log_addr_q.delete();
    log_tag_q.delete();
  endfunction

  function automatic int log_size();
    return log_addr_q.size();
  endfunction

  function automatic addr_t log_addr(input int i);
    return log_addr_q[i];
  endfunction

  function automatic mdata_t log_tag(input int i);
    return log_tag_q[i];
  endfunction

  function automatic int rand_delay();
    return 1 + int'($unsigned($random(seed)) % 6);
  endfunction

  initial begin
    seed = SEED;
    cycle = 0;
    rd_af_seen = 1'b0;
    wr_af_seen = 1'b0;
    proto_err = 2'b00;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    rd_rsp_data = '0;
    wr_rsp_valid = 1'b0;
  end

  always @(posedge clk) begin
    // almostfull values the DUT sampled on the previous edge
    if (rd_req_en === 1'b1 && rd_af_seen) proto_err[0] = 1'b1;
    if (wr_req_en === 1'b1 && wr_af_seen) proto_err[1] = 1'b1;
    rd_af_seen = rd_req_almostfull;
    wr_af_seen = wr_req_almostfull;
    if (rd_req_en === 1'b1) begin
      log_addr_q.push_back(rd_req_addr);
      log_tag_q.push_back(rd_req_mdata);
      rq_data.push_back(peek_line(rd_req_addr));
      rq_tag.push_back(rd_req_mdata);
      rq_due.push_back(cycle + rand_delay());
    end
    if (wr_req_en === 1'b1) begin
      store[wr_req_addr] = wr_req_data;
      wq_due.push_back(cycle + rand_delay());
    end
    cycle++;
    #1;
    // head of line only, so responses keep request order
    rd_rsp_valid = 1'b0;
    if (rq_due.size() > 0 && rq_due[0] <= cycle) begin
      rd_rsp_valid = 1'b1;
      rd_rsp_mdata = rq_tag.pop_front();
      rd_rsp_data = rq_data.pop_front();
      void'(rq_due.pop_front());
    end
    wr_rsp_valid = 1'b0;
    if (wq_due.size() > 0 && wq_due[0] <= cycle) begin
      wr_rsp_valid = 1'b1;
      void'(wq_due.pop_front());
    end
    rd_req_almostfull = bp_enable && ($unsigned($random(seed)) % 3 == 0);
    wr_req_almostfull = bp_enable && ($unsigned($random(seed)) % 3 == 0);
  end

endmodule

//--- tb_top.sv
// testbench top for the convolution core
// runs four jobs against the host memory model, checks every write
// against a reference model, the read order and the done timing
// stops at the first error, times out on a hung job
`timescale 1ns/1ps

module tb_top import conv_pkg::*; ();

  localparam int SEED = 52723;
  localparam int NUM_JOBS = 4;
  localparam int JOB_D [NUM_JOBS] = '{1, 4, 3, 2};
  localparam int JOB_N [NUM_JOBS] = '{1, 6, 10, 9};
  localparam bit JOB_BP [NUM_JOBS] = '{1'b0, 1'b0, 1'b1, 1'b1};
  localparam addr_t ADDR_HI = 58'h2a5_0000_0000_0000;

  logic clk;
  logic reset;
  logic start;
  job_cfg_t cfg;
  logic rd_req_en;
  addr_t rd_req_addr;
  mdata_t rd_req_mdata;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  mdata_t rd_rsp_mdata;
  cacheline_u rd_rsp_data;
  logic wr_req_en;
  addr_t wr_req_addr;
  cacheline_u wr_req_data;
  logic wr_req_almostfull;
  logic wr_rsp_valid;
  logic done;
  logic bp_enable;
  logic [1:0] proto_err;

  job_cfg_t cur_cfg;
  string test_name;
  integer seed;
  int limit;
  int cycle_count = 0;
  int wr_idx = 0;
  int rsp_seen = 0;
  logic done_exp = 1'b0;
  logic clear_pending = 1'b0;

  tb_clock u_clock (
    .clk  (clk),
    .reset(reset)
  );

  tb_memory #(
    .SEED(SEED)
  ) u_mem (
    .clk              (clk),
    .bp_enable        (bp_enable),
    .rd_req_en        (rd_req_en),
    .rd_req_addr      (rd_req_addr),
    .rd_req_mdata     (rd_req_mdata),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp_mdata     (rd_rsp_mdata),
    .rd_rsp_data      (rd_rsp_data),
    .wr_req_en        (wr_req_en),
    .wr_req_addr      (wr_req_addr),
    .wr_req_data      (wr_req_data),
    .wr_req_almostfull(wr_req_almostfull),
    .wr_rsp_valid     (wr_rsp_valid),
    .proto_err        (proto_err)
  );

  conv_top dut (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg              (cfg),
    .rd_req_en        (rd_req_en),
    .rd_req_addr      (rd_req_addr),
    .rd_req_mdata     (rd_req_mdata),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp_mdata     (rd_rsp_mdata),
    .rd_rsp_data      (rd_rsp_data),
    .wr_req_en        (wr_req_en),
    .wr_req_addr      (wr_req_addr),
    .wr_req_data      (wr_req_data),
    .wr_req_almostfull(wr_req_almostfull),
    .wr_rsp_valid     (wr_rsp_valid),
    .done             (done)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_line(input string name, input cacheline_u exp, input cacheline_u act);
    if (act.raw !== exp.raw) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp.raw, act.raw));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_tag(input string name, input mdata_t exp, input mdata_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s %s expected %b actual %b", test_name, name, exp, act));
    end
  endtask

  // output o = sum over d of image line (o*D + d) times kernel line d
  function automatic cacheline_u expected_line(input job_cfg_t job, input int o);
    cacheline_u acc;
    cacheline_u img;
    cacheline_u ker;
    complex_t a;
    complex_t b;
    int d_max;
    acc = '0;
    d_max = int'(job.num_maps);
    for (int d = 0; d < d_max; d++) begin
      img = u_mem.peek_line(job.image_base + addr_t'(o * d_max + d));
      ker = u_mem.peek_line(job.kernel_base + addr_t'(d));
      for (int k = 0; k < CL_LANES; k++) begin
        a = img.lanes[k];
        b = ker.lanes[k];
        acc.lanes[k].re = acc.lanes[k].re + a.re * b.re - a.im * b.im;
        acc.lanes[k].im = acc.lanes[k].im + a.re * b.im + a.im * b.re;
      end
    end
    return acc;
  endfunction

  function automatic int timeout_limit();
    int lines;
    lines = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      lines += JOB_D[j] + JOB_N[j] * JOB_D[j] + JOB_N[j];
    end
    return 40 * lines + 200 * NUM_JOBS;
  endfunction

  function automatic job_cfg_t job_config(input int j);
    job_cfg_t c;
    c.kernel_base = ADDR_HI + addr_t'(32'h1000 * j);
    c.image_base = ADDR_HI + addr_t'(32'h10_0000) + addr_t'(32'h1000 * j);
    c.dest_base = ADDR_HI + addr_t'(32'h20_0000) + addr_t'(32'h100 * j);
    c.num_maps = count_t'(JOB_D[j]);
    c.num_outputs = count_t'(JOB_N[j]);
    return c;
  endfunction

  task automatic fill_lines(input addr_t base, input int count);
    cacheline_u line;
    logic [31:0] w;
    for (int i = 0; i < count; i++) begin
      for (int k = 0; k < 2 * CL_LANES; k++) begin
        w = $random(seed);
        // now and then an extreme value so products and sums wrap
        if ($unsigned($random(seed)) % 8 == 0) begin
          w = w[0] ? 32'h7fff_ffff : 32'h8000_0000;
        end
        line.raw[32*k +: 32] = w;
      end
      u_mem.load_line(base + addr_t'(i), line);
    end
  endtask

  // kernel lines first, then image lines in address order, each once
  task automatic check_read_order(input job_cfg_t c);
    int d;
    int total;
    string name;
    d = int'(c.num_maps);
    total = d + d * int'(c.num_outputs);
    if (u_mem.log_size() != total) begin
      abort_run($sformatf("%s saw %0d read requests where %0d were due",
                          test_name, u_mem.log_size(), total));
    end else begin
      for (int i = 0; i < total; i++) begin
        name = $sformatf("%s read %0d", test_name, i);
        if (i < d) begin
          check_addr(name, c.kernel_base + addr_t'(i), u_mem.log_addr(i));
          check_tag(name, mdata_t'(2 * i + 1), u_mem.log_tag(i));
        end else begin
          check_addr(name, c.image_base + addr_t'(i - d), u_mem.log_addr(i));
          check_tag(name, mdata_t'(2 * ((i - d) % d)), u_mem.log_tag(i));
        end
      end
    end
  endtask

  task automatic run_job(input int j, input string name);
    job_cfg_t c;
    c = job_config(j);
    test_name = name;
    fill_lines(c.kernel_base, JOB_D[j]);
    fill_lines(c.image_base, JOB_D[j] * JOB_N[j]);
    u_mem.clear_log();
    @(posedge clk);
    #1;
    cur_cfg = c;
    bp_enable = JOB_BP[j];
    cfg = c;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // done of the previous job drops first
    while (done !== 1'b0) @(posedge clk);
    while (done !== 1'b1) @(posedge clk);
    if (wr_idx != JOB_N[j]) begin
      abort_run($sformatf("%s finished after %0d of %0d writes", name, wr_idx, JOB_N[j]));
    end else begin
      check_read_order(c);
    end
    repeat (3) @(posedge clk);
  endtask

  // each write request against the reference
  always @(posedge clk) begin
    if (start === 1'b1) wr_idx = 0;
    if (reset === 1'b0 && wr_req_en === 1'b1) begin
      if (wr_idx >= int'(cur_cfg.num_outputs)) begin
        abort_run($sformatf("%s issued a write beyond its last output line", test_name));
      end else begin
        check_addr($sformatf("%s write address %0d", test_name, wr_idx),
                   cur_cfg.dest_base + addr_t'(wr_idx), wr_req_addr);
        check_line($sformatf("%s line %0d", test_name, wr_idx),
                   expected_line(cur_cfg, wr_idx), wr_req_data);
        wr_idx++;
      end
    end
  end

  // done follows the N-th write response and clears with the job start
  always @(posedge clk) begin
    if (reset === 1'b0) begin
      check_flag("done", done_exp, done);
      if (clear_pending) begin
        done_exp = 1'b0;
        rsp_seen = 0;
        clear_pending = 1'b0;
      end else if (wr_rsp_valid === 1'b1) begin
        rsp_seen++;
        if (rsp_seen == int'(cur_cfg.num_outputs)) done_exp = 1'b1;
      end
      if (start === 1'b1) clear_pending = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (proto_err[0]) begin
      abort_run("read request issued in the cycle after read almostfull was high");
    end else if (proto_err[1]) begin
      abort_run("write request issued in the cycle after write almostfull was high");
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > limit) begin
      abort_run($sformatf("timeout after %0d cycles, the job never finished", cycle_count));
    end
  end

  initial begin
    start = 1'b0;
    cfg = '0;
    bp_enable = 1'b0;
    cur_cfg = '0;
    seed = SEED;
    limit = timeout_limit();
    test_name = "idle after reset";
    while (reset !== 1'b0) @(posedge clk);
    repeat (20) begin
      @(posedge clk);
      check_flag("rd_req_en", 1'b0, rd_req_en);
      check_flag("wr_req_en", 1'b0, wr_req_en);
      check_flag("done", 1'b0, done);
    end
    run_job(0, "single product");
    run_job(1, "random wrap");
    run_job(2, "back-pressure");
    run_job(3, "second job");
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- flist.f
conv_pkg.sv
read_sequencer.sv
response_router.sv
mac_lane.sv
write_collector.sv
conv_top.sv
tb_clock.sv
tb_memory.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi
